// ==== matrix_calc_top.f ====
+incdir+rtl
rtl/matrix_pkg.sv
rtl/uart_rx.sv
rtl/matrix_input.sv
rtl/matrix_alu.sv
rtl/result_formatter.sv
rtl/uart_tx.sv
rtl/matrix_calc_top.sv
tests/matrix_calc_tb.sv

// ==== Makefile ====
# Verilator flow for the matrix calculator
# Any variable below can be overridden, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= matrix_calc_tb
RTL_TOP   ?= matrix_calc_top
FILELIST  ?= matrix_calc_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --timing --assert --timescale $(TIMESCALE)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: build
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q '>>> FAIL' $(LOG) || ! grep -q '>>> PASS' $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi; \
	echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/matrix_calc_tb.sv ====
// Testbench driving the calculator through its UART pins only
// Host baud is CLKS_PER_BIT clocks per bit; one frame is in flight at a time
`default_nettype none
`include "matrix_calc_cfg.svh"

module matrix_calc_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CPB        = `CLKS_PER_BIT;
  localparam int MAX_DIM    = `MATRIX_MAX_DIM;
  localparam int MAX_ELEMS  = MAX_DIM * MAX_DIM;
  // Long enough for the biggest input frame plus latency
  localparam int START_WAIT = 50 * 10 * CPB;
  // Quiet time checked after each result
  localparam int IDLE_WAIT  = 2 * 10 * CPB;

  logic       clk;
  logic       reset;
  logic       rxd;
  wire        txd;
  logic [7:0] sw_mode_sel;
  logic [7:0] sw_scalar_val;

  // Stimulus and model state
  logic [31:0]       rng_state;
  logic signed [7:0] mat_a [MAX_ELEMS];
  logic signed [7:0] mat_b [MAX_ELEMS];
  logic [7:0]        send_q [$];
  logic [7:0]        exp_q [$];

  int errors;
  int timeouts;
  int checks;
  int frame_no;

  matrix_calc_top UUT (
    .clk           (clk),
    .reset         (reset),
    .uart_rx       (rxd),
    .uart_tx       (txd),
    .sw_mode_sel   (sw_mode_sel),
    .sw_scalar_val (sw_scalar_val)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ========================================
  // Random numbers
  // ========================================

  // 32-bit xorshift, shifts 13 17 5
  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic int rand_range(int lo, int hi);
    return lo + int'(next_random() % 32'(hi - lo + 1));
  endfunction

  function automatic void fill_operands();
    for (int i = 0; i < MAX_ELEMS; i++) begin
      mat_a[i] = 8'(next_random());
      mat_b[i] = 8'(next_random());
    end
  endfunction

  // ========================================
  // Reference model
  // ========================================

  // High byte first
  function automatic void push_elem16(int value);
    logic [15:0] v;
    v = 16'(value);
    exp_q.push_back(v[15:8]);
    exp_q.push_back(v[7:0]);
  endfunction

  // Operand bytes, row-major; a bad dim cuts the frame at that byte
  function automatic bit push_operand(int rows, int cols, bit use_b);
    bit ok;
    ok = 1'b0;
    send_q.push_back(8'(rows));
    if (rows >= 1 && rows <= MAX_DIM) begin
      send_q.push_back(8'(cols));
      if (cols >= 1 && cols <= MAX_DIM) begin
        ok = 1'b1;
        for (int i = 0; i < rows * cols; i++) begin
          send_q.push_back(use_b ? mat_b[i] : mat_a[i]);
        end
      end
    end
    return ok;
  endfunction

  // Fills the bytes to send and the bytes expected back
  function automatic void build_frame(int mode, logic [7:0] sc,
                                      int ar, int ac, int br, int bc);
    bit dims_ok;
    int value;
    send_q.delete();
    exp_q.delete();
    dims_ok = push_operand(ar, ac, 1'b0);
    // Only add carries a second operand
    if (dims_ok && mode == 1) dims_ok = push_operand(br, bc, 1'b1);
    if (!dims_ok || mode < 1 || mode > 3 || (mode == 1 && (ar != br || ac != bc))) begin
      // Error frame, 0 by 0 and no elements
      exp_q.push_back(8'd0);
      exp_q.push_back(8'd0);
    end else if (mode == 3) begin
      exp_q.push_back(8'(ac));
      exp_q.push_back(8'(ar));
      // Result (r, c) is A (c, r)
      for (int r = 0; r < ac; r++) begin
        for (int c = 0; c < ar; c++) begin
          push_elem16(int'(mat_a[c * ac + r]));
        end
      end
    end else begin
      exp_q.push_back(8'(ar));
      exp_q.push_back(8'(ac));
      for (int i = 0; i < ar * ac; i++) begin
        if (mode == 1) value = int'(mat_a[i]) + int'(mat_b[i]);
        else           value = int'(mat_a[i]) * int'($signed(sc));
        push_elem16(value);
      end
    end
  endfunction

  // ========================================
  // UART driver and monitor
  // ========================================

  // Called on a falling edge, returns on one
  task automatic send_uart_byte(input logic [7:0] b);
    rxd = 1'b0;
    repeat (CPB) @(negedge clk);
    for (int i = 0; i < 8; i++) begin
      rxd = b[i];
      repeat (CPB) @(negedge clk);
    end
    rxd = 1'b1;
    repeat (CPB) @(negedge clk);
  endtask

  // Switches are set before the first byte and held
  task automatic send_frame(input logic [7:0] mode, input logic [7:0] sc);
    @(negedge clk);
    sw_mode_sel   = mode;
    sw_scalar_val = sc;
    foreach (send_q[i]) send_uart_byte(send_q[i]);
  endtask

  // Samples each bit near its middle
  task automatic recv_uart_byte(output logic [7:0] b, output bit ok);
    int waited;
    waited = 0;
    ok     = 1'b0;
    b      = '0;
    while (txd !== 1'b0 && waited < START_WAIT) begin
      @(negedge clk);
      waited++;
    end
    if (txd !== 1'b0) begin
      timeouts++;
      $display("Timeout: no start bit on uart_tx within %0d cycles in frame %0d at %t",
               START_WAIT, frame_no, $time);
    end else begin
      repeat (CPB / 2) @(negedge clk);
      assert (txd === 1'b0) else begin
        errors++;
        $display("Start bit on uart_tx did not stay low at %t", $time);
      end
      for (int i = 0; i < 8; i++) begin
        repeat (CPB) @(negedge clk);
        b[i] = txd;
      end
      repeat (CPB) @(negedge clk);
      assert (txd === 1'b1) else begin
        errors++;
        $display("Stop bit on uart_tx was low at %t", $time);
      end
      ok = 1'b1;
    end
  endtask

  task automatic collect_result();
    logic [7:0] got;
    bit ok;
    ok = 1'b1;
    for (int i = 0; i < exp_q.size() && ok; i++) begin
      recv_uart_byte(got, ok);
      if (ok) begin
        checks++;
        assert (got === exp_q[i]) else begin
          errors++;
          $display("[FAIL] %t frame %0d byte %0d: expected %02h, got %02h",
                   $time, frame_no, i, exp_q[i], got);
        end
      end
    end
  endtask

  // Catches bytes beyond the expected end of a frame
  task automatic check_line_idle();
    int n;
    bit quiet;
    n     = 0;
    quiet = 1'b1;
    while (quiet && n < IDLE_WAIT) begin
      @(negedge clk);
      n++;
      assert (txd === 1'b1) else begin
        errors++;
        quiet = 1'b0;
        $display("Extra byte on uart_tx after frame %0d at %t", frame_no, $time);
      end
    end
  endtask

  // Result collection runs alongside the send
  task automatic run_frame(int mode, logic [7:0] sc, int ar, int ac, int br, int bc);
    if (timeouts == 0) begin
      fill_operands();
      build_frame(mode, sc, ar, ac, br, bc);
      fork
        send_frame(8'(mode), sc);
        collect_result();
      join
      if (timeouts == 0) check_line_idle();
      frame_no++;
    end
  endtask

  // ========================================
  // Test sequence
  // ========================================
  initial begin
    int r;
    int c;
    rng_state     = 32'd3;
    errors        = 0;
    timeouts      = 0;
    checks        = 0;
    frame_no      = 0;
    rxd           = 1'b1;
    sw_mode_sel   = '0;
    sw_scalar_val = '0;
    reset         = 1'b1;
    $timeformat(-9, 0, " ns", 0);
    repeat (16) @(negedge clk);
    reset = 1'b0;
    repeat (4) @(negedge clk);

    // Add, same random shape
    for (int k = 0; k < 3; k++) begin
      r = rand_range(1, MAX_DIM);
      c = rand_range(1, MAX_DIM);
      run_frame(1, 8'(next_random()), r, c, r, c);
    end

    // Scalar multiply, most negative and -1 first
    run_frame(2, 8'h80, MAX_DIM, MAX_DIM, 1, 1);
    run_frame(2, 8'hff, rand_range(1, MAX_DIM), rand_range(1, MAX_DIM), 1, 1);
    for (int k = 0; k < 3; k++) begin
      run_frame(2, 8'(next_random()), rand_range(1, MAX_DIM), rand_range(1, MAX_DIM), 1, 1);
    end

    // Transpose, cols always differ from rows
    for (int k = 0; k < 3; k++) begin
      r = rand_range(1, MAX_DIM);
      c = (r - 1 + rand_range(1, MAX_DIM - 1)) % MAX_DIM + 1;
      run_frame(3, 8'h00, r, c, 1, 1);
    end

    // Shape mismatch and unknown ops
    r = rand_range(1, MAX_DIM);
    c = rand_range(1, MAX_DIM);
    run_frame(1, 8'h00, r, c, r % MAX_DIM + 1, c);
    run_frame(1, 8'h00, r, c, r, c % MAX_DIM + 1);
    run_frame(0, 8'h00, r, c, 1, 1);
    run_frame(rand_range(4, 255), 8'h00, r, c, 1, 1);

    // Cut frames, each followed by a good one
    run_frame(1, 8'h00, 0, 2, 2, 2);
    run_frame(2, 8'hfb, 2, 3, 1, 1);
    run_frame(2, 8'h00, 2, MAX_DIM + 1, 1, 1);
    run_frame(3, 8'h00, 3, 2, 1, 1);

    // Back to back random frames
    for (int k = 0; k < 20; k++) begin
      r = rand_range(1, MAX_DIM);
      c = rand_range(1, MAX_DIM);
      run_frame(rand_range(1, 3), 8'(next_random()), r, c, r, c);
    end

    $display("Frames: %0d  byte checks: %0d  errors: %0d  timeouts: %0d",
             frame_no, checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== rtl/matrix_calc_top.sv ====
// Matrix calculator top: UART in, parse, ALU, format, UART out
// sw_mode_sel and sw_scalar_val are sampled on the first byte of each frame
`default_nettype none

module matrix_calc_top (
  input  wire       clk,
  input  wire       reset,
  input  wire       uart_rx,
  output wire       uart_tx,
  input  wire [7:0] sw_mode_sel,
  input  wire [7:0] sw_scalar_val
);

  // ========================================
  // Stage wires
  // ========================================

  // Receiver to parser
  logic [7:0]           rx_byte;
  logic                 rx_valid;

  // Parser to ALU
  logic                 frame_start;
  matrix_pkg::op_code_t frame_op;
  logic                 frame_error;
  matrix_pkg::dim_t     a_rows;
  matrix_pkg::dim_t     a_cols;
  matrix_pkg::dim_t     b_rows;
  matrix_pkg::dim_t     b_cols;
  matrix_pkg::elem_t    scalar;
  logic                 alu_busy;
  matrix_pkg::index_t   rd_index;
  matrix_pkg::elem_t    a_elem;
  matrix_pkg::elem_t    b_elem;

  // ALU to formatter
  logic                 res_valid;
  logic                 res_is_header;
  matrix_pkg::dim_t     res_rows;
  matrix_pkg::dim_t     res_cols;
  matrix_pkg::result_t  res_data;
  logic                 res_last;
  logic                 fmt_ready;

  // Formatter to transmitter
  logic [7:0]           tx_byte;
  logic                 tx_start;
  logic                 tx_busy;

  // ========================================
  // Pipeline
  // ========================================

  uart_rx u_uart_rx (
    .clk      (clk),
    .reset    (reset),
    .rxd      (uart_rx),
    .rx_byte  (rx_byte),
    .rx_valid (rx_valid)
  );

  matrix_input u_input (
    .clk           (clk),
    .reset         (reset),
    .rx_byte       (rx_byte),
    .rx_valid      (rx_valid),
    .sw_mode_sel   (sw_mode_sel),
    .sw_scalar_val (sw_scalar_val),
    .alu_busy      (alu_busy),
    .frame_start   (frame_start),
    .frame_op      (frame_op),
    .frame_error   (frame_error),
    .a_rows        (a_rows),
    .a_cols        (a_cols),
    .b_rows        (b_rows),
    .b_cols        (b_cols),
    .scalar        (scalar),
    .rd_index      (rd_index),
    .a_elem        (a_elem),
    .b_elem        (b_elem)
  );

  matrix_alu u_alu (
    .clk           (clk),
    .reset         (reset),
    .frame_start   (frame_start),
    .frame_op      (frame_op),
    .frame_error   (frame_error),
    .a_rows        (a_rows),
    .a_cols        (a_cols),
    .b_rows        (b_rows),
    .b_cols        (b_cols),
    .scalar        (scalar),
    .alu_busy      (alu_busy),
    .rd_index      (rd_index),
    .a_elem        (a_elem),
    .b_elem        (b_elem),
    .res_valid     (res_valid),
    .res_is_header (res_is_header),
    .res_rows      (res_rows),
    .res_cols      (res_cols),
    .res_data      (res_data),
    .res_last      (res_last),
    .fmt_ready     (fmt_ready)
  );

  result_formatter u_formatter (
    .clk           (clk),
    .reset         (reset),
    .res_valid     (res_valid),
    .res_is_header (res_is_header),
    .res_rows      (res_rows),
    .res_cols      (res_cols),
    .res_data      (res_data),
    .res_last      (res_last),
    .fmt_ready     (fmt_ready),
    .tx_byte       (tx_byte),
    .tx_start      (tx_start),
    .tx_busy       (tx_busy)
  );

  uart_tx u_uart_tx (
    .clk      (clk),
    .reset    (reset),
    .tx_byte  (tx_byte),
    .tx_start (tx_start),
    .txd      (uart_tx),
    .tx_busy  (tx_busy)
  );

endmodule

`default_nettype wire

// ==== rtl/uart_tx.sv ====
// 8N1 transmitter with a busy level of 10 bit times
// tx_start is taken only while tx_busy is low
`default_nettype none
`include "matrix_calc_cfg.svh"

module uart_tx (
  input  wire        clk,
  input  wire        reset,
  input  wire  [7:0] tx_byte,
  input  wire        tx_start,
  output logic       txd,
  output logic       tx_busy
);

  localparam int CNT_W = $clog2(`CLKS_PER_BIT);

  logic [CNT_W-1:0] clk_cnt;
  logic [3:0]       bit_cnt;
  // Data bits then stop bit
  logic [8:0]       shreg;

  always_ff @(posedge clk) begin
    if (reset) begin
      tx_busy <= 1'b0;
      txd     <= 1'b1;
      clk_cnt <= '0;
      bit_cnt <= '0;
    end else if (!tx_busy) begin
      if (tx_start) begin
        // Start bit goes out right away
        tx_busy <= 1'b1;
        txd     <= 1'b0;
        clk_cnt <= '0;
        bit_cnt <= '0;
      end
    end else if (clk_cnt == CNT_W'(`CLKS_PER_BIT - 1)) begin
      clk_cnt <= '0;
      bit_cnt <= bit_cnt + 1'b1;
      // Line is left high by the stop bit
      if (bit_cnt == 4'd9) tx_busy <= 1'b0;
      else                 txd     <= shreg[0];
    end else begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

  // LSB first
  always_ff @(posedge clk) begin
    if (!tx_busy && tx_start) begin
      shreg <= {1'b1, tx_byte};
    end else if (tx_busy && clk_cnt == CNT_W'(`CLKS_PER_BIT - 1)) begin
      shreg <= {1'b1, shreg[8:1]};
    end
  end

  // The formatter must wait out each byte
  assert property (@(posedge clk) disable iff (reset) tx_start |-> !tx_busy);

endmodule

`default_nettype wire

// ==== rtl/result_formatter.sv ====
// One-item buffer that turns results into bytes for the UART transmitter
// Header is rows then cols; elements go high byte first
`default_nettype none

module result_formatter (
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        res_valid,
  input  wire                        res_is_header,
  input  wire matrix_pkg::dim_t      res_rows,
  input  wire matrix_pkg::dim_t      res_cols,
  input  wire matrix_pkg::result_t   res_data,
  input  wire                        res_last,
  output logic                       fmt_ready,
  output logic [7:0]                 tx_byte,
  output logic                       tx_start,
  input  wire                        tx_busy
);

  matrix_pkg::dim_t    hold_rows;
  matrix_pkg::dim_t    hold_cols;
  matrix_pkg::result_t hold_data;
  logic                hold_header;
  logic                full;
  logic                byte_sel;
  logic                expect_header;
  logic                take;
  logic                send;
  logic [7:0]          next_byte;

  assign fmt_ready = !full;
  assign take      = res_valid && fmt_ready;
  // tx_busy lags tx_start by a cycle
  assign send      = full && !tx_busy && !tx_start;

  always_comb begin
    if (hold_header) begin
      next_byte = byte_sel ? 8'(hold_cols) : 8'(hold_rows);
    end else begin
      next_byte = byte_sel ? hold_data[7:0] : hold_data[15:8];
    end
  end

  // Two bytes per item
  // Buffer frees with the second byte
  always_ff @(posedge clk) begin
    if (reset) begin
      full          <= 1'b0;
      byte_sel      <= 1'b0;
      tx_start      <= 1'b0;
      expect_header <= 1'b1;
    end else begin
      tx_start <= send;
      if (take) begin
        full          <= 1'b1;
        byte_sel      <= 1'b0;
        expect_header <= res_last;
      end else if (send) begin
        byte_sel <= 1'b1;
        if (byte_sel) full <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      hold_header <= res_is_header;
      hold_rows   <= res_rows;
      hold_cols   <= res_cols;
      hold_data   <= res_data;
    end
    if (send) tx_byte <= next_byte;
  end

  // Each frame opens with one header and the last item closes it
  assert property (@(posedge clk) disable iff (reset)
    take |-> (res_is_header == expect_header));

endmodule

`default_nettype wire

// ==== rtl/matrix_alu.sv ====
// Element-by-element ALU for add, scalar multiply and transpose
// Frame fields must stay stable from frame_start until the last item is taken
`default_nettype none
`include "matrix_calc_cfg.svh"

module matrix_alu (
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        frame_start,
  input  wire matrix_pkg::op_code_t  frame_op,
  input  wire                        frame_error,
  input  wire matrix_pkg::dim_t      a_rows,
  input  wire matrix_pkg::dim_t      a_cols,
  input  wire matrix_pkg::dim_t      b_rows,
  input  wire matrix_pkg::dim_t      b_cols,
  input  wire matrix_pkg::elem_t     scalar,
  output logic                       alu_busy,
  output matrix_pkg::index_t         rd_index,
  input  wire matrix_pkg::elem_t     a_elem,
  input  wire matrix_pkg::elem_t     b_elem,
  output logic                       res_valid,
  output logic                       res_is_header,
  output matrix_pkg::dim_t           res_rows,
  output matrix_pkg::dim_t           res_cols,
  output matrix_pkg::result_t        res_data,
  output logic                       res_last,
  input  wire                        fmt_ready
);

  localparam int DIM = `MATRIX_MAX_DIM;

  matrix_pkg::dim_t    row;
  matrix_pkg::dim_t    col;
  matrix_pkg::result_t elem_val;
  logic                transpose;
  logic                fault;
  logic                xfer;
  logic                col_end;
  logic                last_elem;

  assign transpose = (frame_op == matrix_pkg::OP_TRANSPOSE);
  // Shape mismatch on add, or a fault flagged by the parser
  assign fault = frame_error ||
                 ((frame_op == matrix_pkg::OP_ADD) &&
                  ((a_rows != b_rows) || (a_cols != b_cols)));
  assign xfer      = res_valid && fmt_ready;
  assign col_end   = (col == res_cols - 1'b1);
  assign last_elem = col_end && (row == res_rows - 1'b1);

  // Row and col count the result, so transpose reads A swapped
  assign rd_index = transpose ? matrix_pkg::index_t'(col * DIM + row)
                              : matrix_pkg::index_t'(row * DIM + col);

  // Sign-extend before the math
  always_comb begin
    case (frame_op)
      matrix_pkg::OP_ADD:
        elem_val = matrix_pkg::result_t'(a_elem) + matrix_pkg::result_t'(b_elem);
      matrix_pkg::OP_SCALE:
        elem_val = matrix_pkg::result_t'(a_elem) * matrix_pkg::result_t'(scalar);
      default:
        elem_val = matrix_pkg::result_t'(a_elem);
    endcase
  end

  // Valid stays up until the last item goes
  always_ff @(posedge clk) begin
    if (reset) begin
      alu_busy  <= 1'b0;
      res_valid <= 1'b0;
    end else if (frame_start) begin
      alu_busy  <= 1'b1;
      res_valid <= 1'b1;
    end else if (xfer && res_last) begin
      alu_busy  <= 1'b0;
      res_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (frame_start) begin
      // Header first
      // A faulty frame ends with the 0 by 0 header
      res_is_header <= 1'b1;
      res_last      <= fault;
      res_rows      <= fault ? '0 : (transpose ? a_cols : a_rows);
      res_cols      <= fault ? '0 : (transpose ? a_rows : a_cols);
      row           <= '0;
      col           <= '0;
    end else if (xfer && !res_last) begin
      res_is_header <= 1'b0;
      res_data      <= elem_val;
      res_last      <= last_elem;
      col           <= col_end ? '0 : col + 1'b1;
      if (col_end) row <= row + 1'b1;
    end
  end

  // Offered item holds while the formatter is full
  assert property (@(posedge clk) disable iff (reset)
    res_valid && !fmt_ready |=> res_valid && $stable(res_data) &&
                                $stable(res_is_header) && $stable(res_last) &&
                                $stable(res_rows) && $stable(res_cols));

endmodule

`default_nettype wire

// ==== rtl/matrix_input.sv ====
// Frame parser and operand buffers; op and scalar are taken on the first byte
// Bytes seen while alu_busy is high are dropped since UART cannot be stalled
`default_nettype none
`include "matrix_calc_cfg.svh"

module matrix_input (
  input  wire                      clk,
  input  wire                      reset,
  input  wire  [7:0]               rx_byte,
  input  wire                      rx_valid,
  input  wire  [7:0]               sw_mode_sel,
  input  wire  [7:0]               sw_scalar_val,
  input  wire                      alu_busy,
  output logic                     frame_start,
  output matrix_pkg::op_code_t     frame_op,
  output logic                     frame_error,
  output matrix_pkg::dim_t         a_rows,
  output matrix_pkg::dim_t         a_cols,
  output matrix_pkg::dim_t         b_rows,
  output matrix_pkg::dim_t         b_cols,
  output matrix_pkg::elem_t        scalar,
  input  wire matrix_pkg::index_t  rd_index,
  output matrix_pkg::elem_t        a_elem,
  output matrix_pkg::elem_t        b_elem
);

  localparam int DIM = `MATRIX_MAX_DIM;

  typedef enum logic [1:0] {S_ROWS, S_COLS, S_ELEMS} state_t;

  state_t               state;
  logic                 opnd_b;
  matrix_pkg::dim_t     cnt_row;
  matrix_pkg::dim_t     cnt_col;
  matrix_pkg::dim_t     cur_rows;
  matrix_pkg::dim_t     cur_cols;
  matrix_pkg::op_code_t op_dec;
  matrix_pkg::index_t   wr_index;
  logic                 accept;
  logic                 first_byte;
  logic                 dim_bad;
  logic                 row_end;
  logic                 opnd_end;

  matrix_pkg::elem_t    buf_a [DIM*DIM];
  matrix_pkg::elem_t    buf_b [DIM*DIM];

  // Switch code to op
  always_comb begin
    case (sw_mode_sel)
      8'd1:    op_dec = matrix_pkg::OP_ADD;
      8'd2:    op_dec = matrix_pkg::OP_SCALE;
      8'd3:    op_dec = matrix_pkg::OP_TRANSPOSE;
      default: op_dec = matrix_pkg::OP_NONE;
    endcase
  end

  assign accept     = rx_valid && !alu_busy;
  assign first_byte = (state == S_ROWS) && !opnd_b;
  assign dim_bad    = (rx_byte == 8'd0) || (rx_byte > 8'(DIM));
  assign cur_rows   = opnd_b ? b_rows : a_rows;
  assign cur_cols   = opnd_b ? b_cols : a_cols;
  assign wr_index   = matrix_pkg::index_t'(cnt_row * DIM + cnt_col);
  assign row_end    = (cnt_col == cur_cols - 1'b1);
  assign opnd_end   = row_end && (cnt_row == cur_rows - 1'b1);

  // ========================================
  // Frame FSM
  // ========================================
  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= S_ROWS;
      opnd_b      <= 1'b0;
      cnt_row     <= '0;
      cnt_col     <= '0;
      frame_start <= 1'b0;
      frame_error <= 1'b0;
    end else begin
      frame_start <= 1'b0;
      if (accept) begin
        case (state)
          S_ROWS, S_COLS: begin
            if (dim_bad) begin
              // Frame ends at the bad byte
              frame_start <= 1'b1;
              frame_error <= 1'b1;
              opnd_b      <= 1'b0;
              state       <= S_ROWS;
            end else begin
              cnt_row <= '0;
              cnt_col <= '0;
              state   <= (state == S_ROWS) ? S_COLS : S_ELEMS;
            end
          end
          S_ELEMS: begin
            cnt_col <= row_end ? '0 : cnt_col + 1'b1;
            if (row_end) cnt_row <= cnt_row + 1'b1;
            if (opnd_end) begin
              state <= S_ROWS;
              // Add needs B next
              if (!opnd_b && frame_op == matrix_pkg::OP_ADD) begin
                opnd_b <= 1'b1;
              end else begin
                opnd_b      <= 1'b0;
                frame_start <= 1'b1;
                frame_error <= (frame_op == matrix_pkg::OP_NONE);
              end
            end
          end
          default: state <= S_ROWS;
        endcase
      end
    end
  end

  // ========================================
  // Frame fields and operand buffers
  // ========================================
  always_ff @(posedge clk) begin
    if (accept) begin
      if (first_byte) begin
        frame_op <= op_dec;
        scalar   <= matrix_pkg::elem_t'(sw_scalar_val);
      end
      if (!dim_bad && state == S_ROWS) begin
        if (opnd_b) b_rows <= matrix_pkg::dim_t'(rx_byte);
        else        a_rows <= matrix_pkg::dim_t'(rx_byte);
      end
      if (!dim_bad && state == S_COLS) begin
        if (opnd_b) b_cols <= matrix_pkg::dim_t'(rx_byte);
        else        a_cols <= matrix_pkg::dim_t'(rx_byte);
      end
      if (state == S_ELEMS) begin
        if (opnd_b) buf_b[wr_index] <= matrix_pkg::elem_t'(rx_byte);
        else        buf_a[wr_index] <= matrix_pkg::elem_t'(rx_byte);
      end
    end
  end

  // ALU read port
  assign a_elem = buf_a[rd_index];
  assign b_elem = buf_b[rd_index];

  // A new frame only reaches an idle ALU
  assert property (@(posedge clk) disable iff (reset) frame_start |-> !alu_busy);

endmodule

`default_nettype wire

// ==== rtl/uart_rx.sv ====
// 8N1 receiver with one strobe per byte
// Bytes with a low stop bit are dropped silently
`default_nettype none
`include "matrix_calc_cfg.svh"

module uart_rx (
  input  wire        clk,
  input  wire        reset,
  input  wire        rxd,
  output logic [7:0] rx_byte,
  output logic       rx_valid
);

  localparam int CNT_W = $clog2(`CLKS_PER_BIT);

  typedef enum logic [1:0] {S_IDLE, S_START, S_DATA, S_STOP} state_t;

  state_t           state;
  logic [1:0]       rx_sync;
  logic [CNT_W-1:0] clk_cnt;
  logic [2:0]       bit_cnt;
  logic             bit_end;

  // Two flop synchronizer
  // Line idles high
  always_ff @(posedge clk) begin
    if (reset) begin
      rx_sync <= 2'b11;
    end else begin
      rx_sync <= {rx_sync[0], rxd};
    end
  end

  assign bit_end = (clk_cnt == CNT_W'(`CLKS_PER_BIT - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= S_IDLE;
      clk_cnt  <= '0;
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      clk_cnt  <= clk_cnt + 1'b1;
      case (state)
        S_IDLE: begin
          clk_cnt <= '0;
          if (!rx_sync[1]) state <= S_START;
        end
        // Recheck the start bit at mid-bit to reject glitches
        S_START: begin
          if (clk_cnt == CNT_W'(`CLKS_PER_BIT / 2 - 1)) begin
            clk_cnt <= '0;
            bit_cnt <= '0;
            state   <= rx_sync[1] ? S_IDLE : S_DATA;
          end
        end
        // LSB first
        S_DATA: begin
          if (bit_end) begin
            clk_cnt <= '0;
            rx_byte <= {rx_sync[1], rx_byte[7:1]};
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) state <= S_STOP;
          end
        end
        S_STOP: begin
          if (bit_end) begin
            rx_valid <= rx_sync[1];
            state    <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/matrix_pkg.sv ====
// Types shared by the matrix pipeline
// Widths follow the macros in the config header
`default_nettype none
`include "matrix_calc_cfg.svh"

package matrix_pkg;

  // Operation selected for a frame
  // OP_NONE marks an unknown op code
  typedef enum logic [1:0] {
    OP_NONE      = 2'd0,
    OP_ADD       = 2'd1,
    OP_SCALE     = 2'd2,
    OP_TRANSPOSE = 2'd3
  } op_code_t;

  // Row or column count, 0 up to MATRIX_MAX_DIM
  typedef logic [$clog2(`MATRIX_MAX_DIM + 1)-1:0] dim_t;

  // Flat buffer index
  // row * MATRIX_MAX_DIM + col
  typedef logic [$clog2(`MATRIX_MAX_DIM * `MATRIX_MAX_DIM)-1:0] index_t;

  // Signed operand element
  typedef logic signed [`ELEM_W-1:0] elem_t;

  // Signed result element
  typedef logic signed [`RESULT_W-1:0] result_t;

endpackage

`default_nettype wire

// ==== rtl/matrix_calc_cfg.svh ====
// Build constants shared by the RTL and the testbench
// The host baud rate must equal the clock rate divided by CLKS_PER_BIT
`ifndef MATRIX_CALC_CFG_SVH
`define MATRIX_CALC_CFG_SVH

// ========================================
// UART timing
// ========================================

// Clock cycles per UART bit
// Kept small so that simulation stays fast
`define CLKS_PER_BIT 16

// ========================================
// Matrix sizing
// ========================================

// Largest row or column count of an operand
`define MATRIX_MAX_DIM 4

// Operand element width
`define ELEM_W 8

// Result element width
`define RESULT_W 16

`endif
